// File: common/group_defines.svh
`ifndef GROUP_DEFINES_SVH
`define GROUP_DEFINES_SVH

// Stream sample width
`define GRP_DATA_W 27

// Batch-norm coefficients
`define GRP_COEF_A_W 17
`define GRP_COEF_B_W 34

// Parameter word with the scale above the offset
`define GRP_PARAM_W 60

// Right shift after scaling
`define GRP_QUANT_W 16

`define GRP_BRANCHES 2

// Input to output, in cycles
`define GRP_LATENCY 3

`endif

// File: common/group_pkg.sv
package group_pkg;

	`include "group_defines.svh"

	// Stream sample
	typedef logic signed [`GRP_DATA_W-1:0] sample_t;

	// Scale in bits 50..34 of the parameter word
	typedef logic signed [`GRP_COEF_A_W-1:0] coef_a_t;

	// Offset in bits 33..0 of the parameter word
	typedef logic signed [`GRP_COEF_B_W-1:0] coef_b_t;

	// Top bits above the scale are unused
	typedef logic [`GRP_PARAM_W-1:0] param_t;

	// One-hot branch select for a coefficient write
	typedef logic [`GRP_BRANCHES-1:0] branch_sel_t;

	// Per-branch loader state
	typedef enum logic
	{
		LOAD_IDLE,
		LOAD_PENDING
	} load_state_t;

endpackage

// File: common/pix_stream_if.sv
`timescale 1ns/1ns

interface pix_stream_if
	import group_pkg::*;
();

	logic    vsync;
	logic    hsync;
	logic    reuse;
	logic    valid;
	sample_t data;

	modport src
	(
		output vsync,
		output hsync,
		output reuse,
		output valid,
		output data
	);

	modport snk
	(
		input vsync,
		input hsync,
		input reuse,
		input valid,
		input data
	);

endinterface

// File: hw/param_loader.sv
`timescale 1ns/1ns

`include "group_defines.svh"

module param_loader
	import group_pkg::*;
(
	input  logic        i_sclk,
	input  logic        i_rst,
	input  logic        i_vsync,
	input  branch_sel_t i_param_vld,
	input  param_t      i_param,
	output coef_a_t     o_coef_a [`GRP_BRANCHES],
	output coef_b_t     o_coef_b [`GRP_BRANCHES]
);

	coef_a_t     wr_a;
	coef_b_t     wr_b;
	coef_a_t     pend_a [`GRP_BRANCHES];
	coef_b_t     pend_b [`GRP_BRANCHES];
	load_state_t state  [`GRP_BRANCHES];

	// Split the parameter word
	assign wr_b = i_param[`GRP_COEF_B_W-1:0];
	assign wr_a = i_param[`GRP_COEF_B_W +: `GRP_COEF_A_W];

	always_ff @(posedge i_sclk)
	begin
		for (int b = 0; b < `GRP_BRANCHES; b++)
		begin
			if (i_param_vld[b])
			begin
				pend_a[b] <= wr_a;
				pend_b[b] <= wr_b;
			end
		end
	end

	// A write landing on the vsync cycle waits for the next vsync
	// because the transfer takes the pending value from before that edge
	always_ff @(posedge i_sclk)
	begin
		if (i_rst)
		begin
			for (int b = 0; b < `GRP_BRANCHES; b++)
			begin
				state[b]    <= LOAD_IDLE;
				o_coef_a[b] <= '0;
				o_coef_b[b] <= '0;
			end
		end
		else
		begin
			for (int b = 0; b < `GRP_BRANCHES; b++)
			begin
				case (state[b])
					LOAD_IDLE:
					begin
						if (i_param_vld[b])
							state[b] <= LOAD_PENDING;
					end
					LOAD_PENDING:
					begin
						if (i_vsync)
						begin
							o_coef_a[b] <= pend_a[b];
							o_coef_b[b] <= pend_b[b];
							state[b]    <= i_param_vld[b] ? LOAD_PENDING : LOAD_IDLE;
						end
					end
					default:
						state[b] <= LOAD_IDLE;
				endcase
			end
		end
	end

	// At most one branch written per cycle
	a_sel_onehot: assert property (
		@(posedge i_sclk) disable iff (i_rst)
		$onehot0(i_param_vld)
	);

endmodule

// File: bnorm/batch_norm.sv
`timescale 1ns/1ns

`include "group_defines.svh"

module batch_norm
	import group_pkg::*;
(
	input  logic         i_sclk,
	input  logic         i_rst,
	pix_stream_if.snk    i_stream,
	input  coef_a_t      i_coef_a,
	input  coef_b_t      i_coef_b,
	pix_stream_if.src    o_stream
);

	// Product plus offset with one guard bit
	localparam int ACC_W = `GRP_DATA_W + `GRP_COEF_A_W + 1;

	logic signed [ACC_W-1:0] acc_q;
	logic signed [ACC_W-1:0] shifted;
	logic                    ovf;
	sample_t                 data_sat;
	sample_t                 data_q;
	logic [3:0]              flags_q1;
	logic [3:0]              flags_q2;

	// Stage one
	always_ff @(posedge i_sclk)
	begin
		acc_q <= i_stream.data * i_coef_a + i_coef_b;
	end

	// Stage two shifts arithmetically and then clamps
	always_comb
	begin
		shifted  = acc_q >>> `GRP_QUANT_W;
		ovf      = !(&shifted[ACC_W-1:`GRP_DATA_W-1] || ~|shifted[ACC_W-1:`GRP_DATA_W-1]);
		data_sat = shifted[`GRP_DATA_W-1:0];
		if (ovf)
			data_sat = {shifted[ACC_W-1], {(`GRP_DATA_W-1){~shifted[ACC_W-1]}}};
	end

	always_ff @(posedge i_sclk)
	begin
		data_q <= data_sat;
	end

	// Flags as {vsync, hsync, reuse, valid}
	always_ff @(posedge i_sclk)
	begin
		if (i_rst)
		begin
			flags_q1 <= '0;
			flags_q2 <= '0;
		end
		else
		begin
			flags_q1 <= {i_stream.vsync, i_stream.hsync, i_stream.reuse, i_stream.valid};
			flags_q2 <= flags_q1;
		end
	end

	assign o_stream.vsync = flags_q2[3];
	assign o_stream.hsync = flags_q2[2];
	assign o_stream.reuse = flags_q2[1];
	assign o_stream.valid = flags_q2[0];
	assign o_stream.data  = data_q;

	a_valid_delay: assert property (
		@(posedge i_sclk) disable iff (i_rst)
		(!$past(i_rst, 1) && !$past(i_rst, 2)) |-> (o_stream.valid == $past(i_stream.valid, 2))
	);

endmodule

// File: hw/residual_add.sv
`timescale 1ns/1ns

`include "group_defines.svh"

module residual_add
	import group_pkg::*;
(
	input  logic      i_sclk,
	input  logic      i_rst,
	pix_stream_if.snk i_branch_a,
	pix_stream_if.snk i_branch_b,
	output logic      o_vsync,
	output logic      o_hsync,
	output logic      o_reuse,
	output logic      o_valid,
	output sample_t   o_tdata
);

	logic signed [`GRP_DATA_W:0] sum;
	sample_t                     sum_sat;
	sample_t                     data_q;

	always_comb
	begin
		sum     = i_branch_a.data + i_branch_b.data;
		sum_sat = sum[`GRP_DATA_W-1:0];
		// Carry and sign disagree on overflow
		if (sum[`GRP_DATA_W] != sum[`GRP_DATA_W-1])
			sum_sat = {sum[`GRP_DATA_W], {(`GRP_DATA_W-1){~sum[`GRP_DATA_W]}}};
	end

	always_ff @(posedge i_sclk)
	begin
		data_q <= sum_sat;
	end

	// Flags follow branch a
	always_ff @(posedge i_sclk)
	begin
		if (i_rst)
		begin
			o_vsync <= 1'b0;
			o_hsync <= 1'b0;
			o_reuse <= 1'b0;
			o_valid <= 1'b0;
		end
		else
		begin
			o_vsync <= i_branch_a.vsync;
			o_hsync <= i_branch_a.hsync;
			o_reuse <= i_branch_a.reuse;
			o_valid <= i_branch_a.valid;
		end
	end

	assign o_tdata = o_valid ? data_q : '0;

	// Both branches run in lockstep
	a_branch_valid: assert property (
		@(posedge i_sclk) disable iff (i_rst)
		i_branch_a.valid == i_branch_b.valid
	);

endmodule

// File: hw/cnn_group_top.sv
`timescale 1ns/1ns

`include "group_defines.svh"

module cnn_group_top
	import group_pkg::*;
(
	input  logic        i_sclk,
	input  logic        i_rst,
	input  logic        i_vsync,
	input  logic        i_hsync,
	input  logic        i_reuse,
	input  logic        i_valid,
	input  sample_t     i_tdata,
	input  branch_sel_t i_param_vld,
	input  param_t      i_param,
	output logic        o_vsync,
	output logic        o_hsync,
	output logic        o_reuse,
	output logic        o_valid,
	output sample_t     o_tdata
);

	coef_a_t coef_a [`GRP_BRANCHES];
	coef_b_t coef_b [`GRP_BRANCHES];

	pix_stream_if in_stream ();
	pix_stream_if main_stream ();
	pix_stream_if side_stream ();

	assign in_stream.vsync = i_vsync;
	assign in_stream.hsync = i_hsync;
	assign in_stream.reuse = i_reuse;
	assign in_stream.valid = i_valid;
	assign in_stream.data  = i_tdata;

	param_loader param_loader_inst (
		.i_sclk      (i_sclk),
		.i_rst       (i_rst),
		.i_vsync     (i_vsync),
		.i_param_vld (i_param_vld),
		.i_param     (i_param),
		.o_coef_a    (coef_a),
		.o_coef_b    (coef_b)
	);

	// Branch 0
	batch_norm bn_main (
		.i_sclk   (i_sclk),
		.i_rst    (i_rst),
		.i_stream (in_stream),
		.i_coef_a (coef_a[0]),
		.i_coef_b (coef_b[0]),
		.o_stream (main_stream)
	);

	// Branch 1
	batch_norm bn_side (
		.i_sclk   (i_sclk),
		.i_rst    (i_rst),
		.i_stream (in_stream),
		.i_coef_a (coef_a[1]),
		.i_coef_b (coef_b[1]),
		.o_stream (side_stream)
	);

	residual_add residual_add_inst (
		.i_sclk     (i_sclk),
		.i_rst      (i_rst),
		.i_branch_a (main_stream),
		.i_branch_b (side_stream),
		.o_vsync    (o_vsync),
		.o_hsync    (o_hsync),
		.o_reuse    (o_reuse),
		.o_valid    (o_valid),
		.o_tdata    (o_tdata)
	);

endmodule

// File: sim/tb_cnn_group.sv
`timescale 1ns/1ns

`include "group_defines.svh"

module tb_cnn_group
	import group_pkg::*;
();

	localparam int     TBL_MAX = 128;
	localparam longint S_MAX   = (longint'(1) <<< (`GRP_DATA_W-1)) - 1;
	localparam longint S_MIN   = -(longint'(1) <<< (`GRP_DATA_W-1));
	localparam coef_b_t B_MAX  = {1'b0, {(`GRP_COEF_B_W-1){1'b1}}};
	localparam coef_b_t B_MIN  = {1'b1, {(`GRP_COEF_B_W-1){1'b0}}};

	typedef struct packed
	{
		int          test;
		branch_sel_t sel;
		param_t      word;
		logic        vsync;
		logic        hsync;
		logic        reuse;
		logic        valid;
		sample_t     data;
		sample_t     exp_data;
	} entry_t;

	logic        i_sclk = 1'b0;
	logic        i_rst;
	logic        i_vsync;
	logic        i_hsync;
	logic        i_reuse;
	logic        i_valid;
	sample_t     i_tdata;
	branch_sel_t i_param_vld;
	param_t      i_param;
	logic        o_vsync;
	logic        o_hsync;
	logic        o_reuse;
	logic        o_valid;
	sample_t     o_tdata;

	entry_t  tbl [TBL_MAX];
	int      n_entries;
	int      exp_q [$];
	integer  seed;
	int      cycles = 0;
	int      cycle_limit;
	int      n_checks;
	int      n_errors;
	int      cur_test;
	int      test_checks [7];
	int      test_errors [7];
	string   test_name [7];

	// Reference loader state
	coef_a_t act_a  [`GRP_BRANCHES];
	coef_b_t act_b  [`GRP_BRANCHES];
	coef_a_t pend_a [`GRP_BRANCHES];
	coef_b_t pend_b [`GRP_BRANCHES];
	logic    pend_flag [`GRP_BRANCHES];

	cnn_group_top cnn_group_top_inst (
		.i_sclk      (i_sclk),
		.i_rst       (i_rst),
		.i_vsync     (i_vsync),
		.i_hsync     (i_hsync),
		.i_reuse     (i_reuse),
		.i_valid     (i_valid),
		.i_tdata     (i_tdata),
		.i_param_vld (i_param_vld),
		.i_param     (i_param),
		.o_vsync     (o_vsync),
		.o_hsync     (o_hsync),
		.o_reuse     (o_reuse),
		.o_valid     (o_valid),
		.o_tdata     (o_tdata)
	);

	always
	begin
		#4 i_sclk = ~i_sclk;
	end

	always @(posedge i_sclk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("Timeout: outputs not fully checked after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic sample_t clamp_sample(input longint v);
		if (v > S_MAX)
			return sample_t'(S_MAX);
		if (v < S_MIN)
			return sample_t'(S_MIN);
		return sample_t'(v);
	endfunction

	function automatic sample_t branch_model(input sample_t x, input coef_a_t a, input coef_b_t b);
		longint acc;
		acc = longint'(x) * longint'(a) + longint'(b);
		return clamp_sample(acc >>> `GRP_QUANT_W);
	endfunction

	function automatic param_t make_param(input coef_a_t a, input coef_b_t b);
		return {{(`GRP_PARAM_W-`GRP_COEF_A_W-`GRP_COEF_B_W){1'b0}}, a, b};
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'($random(seed));
	endfunction

	// Expected output uses the coefficients active before this cycle's vsync
	task automatic add_entry(input int test, input branch_sel_t sel, input param_t word,
		input logic vs, input logic hs, input logic ru, input logic vl, input sample_t data);
		entry_t e;
		longint sum;
		sum = 0;
		for (int b = 0; b < `GRP_BRANCHES; b++)
			sum += longint'(branch_model(data, act_a[b], act_b[b]));
		e.test     = test;
		e.sel      = sel;
		e.word     = word;
		e.vsync    = vs;
		e.hsync    = hs;
		e.reuse    = ru;
		e.valid    = vl;
		e.data     = data;
		e.exp_data = vl ? clamp_sample(sum) : '0;
		tbl[n_entries] = e;
		n_entries++;
		for (int b = 0; b < `GRP_BRANCHES; b++)
		begin
			if (pend_flag[b] && vs)
			begin
				act_a[b]     = pend_a[b];
				act_b[b]     = pend_b[b];
				pend_flag[b] = sel[b];
			end
			else if (sel[b])
				pend_flag[b] = 1'b1;
			if (sel[b])
			begin
				pend_a[b] = word[`GRP_COEF_B_W +: `GRP_COEF_A_W];
				pend_b[b] = word[`GRP_COEF_B_W-1:0];
			end
		end
	endtask

	task automatic add_sample(input int test, input sample_t data);
		add_entry(test, '0, '0, 1'b0, 1'b0, 1'b0, 1'b1, data);
	endtask

	task automatic add_load(input int test, input branch_sel_t sel, input coef_a_t a,
		input coef_b_t b);
		add_entry(test, sel, make_param(a, b), 1'b0, 1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic build_table();
		repeat (4) add_sample(1, rand_sample());
		// Branch 0 halves while branch 1 stays zero
		add_load(2, 2'b01, 32768, 0);
		add_entry(2, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		repeat (8) add_sample(2, rand_sample());
		add_load(3, 2'b01, 20000, 123456789);
		add_load(3, 2'b10, -45000, -987654321);
		add_entry(3, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		repeat (10) add_sample(3, rand_sample());
		add_load(4, 2'b01, 65535, B_MAX);
		add_load(4, 2'b10, 65535, B_MIN);
		add_entry(4, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		add_sample(4, sample_t'(S_MAX));
		add_sample(4, sample_t'(S_MIN));
		add_sample(4, 1000);
		add_sample(4, 40000000);
		add_sample(4, -40000000);
		add_sample(4, -1);
		add_sample(4, 0);
		add_sample(4, rand_sample());
		// Write while streaming without vsync
		add_entry(5, 2'b01, make_param(16384, 1 << 20), 1'b0, 1'b0, 1'b0, 1'b1, rand_sample());
		repeat (4) add_sample(5, rand_sample());
		add_entry(5, 2'b10, make_param(-20000, 5000), 1'b1, 1'b0, 1'b0, 1'b1, rand_sample());
		repeat (4) add_sample(5, rand_sample());
		add_entry(5, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0);
		repeat (4) add_sample(5, rand_sample());
		for (int i = 0; i < 16; i++)
			add_entry(6, '0, '0, (i == 5) || (i == 11), (i % 3) == 0, (i % 2) == 1,
				(i % 4) != 1, rand_sample());
		// Idle cycles to flush the pipeline
		repeat (`GRP_LATENCY) add_entry(6, '0, '0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic check_value(input string name, input logic signed [63:0] got,
		input logic signed [63:0] expv, input int test);
		n_checks++;
		test_checks[test]++;
		if (got !== expv)
		begin
			$display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, expv);
			n_errors++;
			test_errors[test]++;
		end
	endtask

	task automatic report_test(input int test);
		$display("test %0d %s: %0d checks, %0d errors", test, test_name[test],
			test_checks[test], test_errors[test]);
	endtask

	// Index -1 stands for an idle output
	task automatic compare_entry(input int idx);
		entry_t e;
		e      = '0;
		e.test = 1;
		if (idx >= 0)
			e = tbl[idx];
		if (e.test != cur_test)
		begin
			report_test(cur_test);
			cur_test = e.test;
		end
		check_value("o_valid", o_valid, e.valid, e.test);
		check_value("o_vsync", o_vsync, e.vsync, e.test);
		check_value("o_hsync", o_hsync, e.hsync, e.test);
		check_value("o_reuse", o_reuse, e.reuse, e.test);
		check_value("o_tdata", o_tdata, e.exp_data, e.test);
	endtask

	task automatic apply_entry(input int idx);
		i_param_vld <= tbl[idx].sel;
		i_param     <= tbl[idx].word;
		i_vsync     <= tbl[idx].vsync;
		i_hsync     <= tbl[idx].hsync;
		i_reuse     <= tbl[idx].reuse;
		i_valid     <= tbl[idx].valid;
		i_tdata     <= tbl[idx].data;
	endtask

	initial
	begin
		i_rst       = 1'b1;
		i_vsync     = 1'b0;
		i_hsync     = 1'b0;
		i_reuse     = 1'b0;
		i_valid     = 1'b0;
		i_tdata     = '0;
		i_param_vld = '0;
		i_param     = '0;
		seed        = 44447;
		n_entries   = 0;
		n_checks    = 0;
		n_errors    = 0;
		cur_test    = 1;
		test_name   = '{"", "reset", "single branch", "two branches", "saturation",
			"update timing", "flags and gating"};
		for (int b = 0; b < `GRP_BRANCHES; b++)
		begin
			act_a[b]     = '0;
			act_b[b]     = '0;
			pend_a[b]    = '0;
			pend_b[b]    = '0;
			pend_flag[b] = 1'b0;
		end
		build_table();
		cycle_limit = n_entries + `GRP_LATENCY + 20;

		for (int r = 0; r < 3; r++)
		begin
			@(posedge i_sclk);
			if (r == 2)
				i_rst <= 1'b0;
			@(negedge i_sclk);
			compare_entry(-1);
		end

		repeat (`GRP_LATENCY) exp_q.push_back(-1);
		for (int i = 0; i < n_entries; i++)
		begin
			@(posedge i_sclk);
			apply_entry(i);
			exp_q.push_back(i);
			@(negedge i_sclk);
			if (exp_q.size() > `GRP_LATENCY)
				compare_entry(exp_q.pop_front());
		end
		report_test(cur_test);

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src.f
+incdir+common
common/group_pkg.sv
common/pix_stream_if.sv
hw/param_loader.sv
bnorm/batch_norm.sv
hw/residual_add.sv
hw/cnn_group_top.sv
sim/tb_cnn_group.sv

// File: Bender.yml
package:
  name: cnn_group

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/group_pkg.sv
      - common/pix_stream_if.sv
      - hw/param_loader.sv
      - bnorm/batch_norm.sv
      - hw/residual_add.sv
      - hw/cnn_group_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_cnn_group.sv
